// ==== verilog/dds_scope_params.svh ====
`ifndef DDS_SCOPE_PARAMS_SVH
`define DDS_SCOPE_PARAMS_SVH

// datapath widths
`define PHASE_W            32
`define SAMPLE_W           12
`define KEY_COUNT          12

`define LFSR_TICK          20       // clocks per lfsr step
`define TRACE_DEPTH        16       // samples per trace
`define TRACE_DECIM        5        // clocks between samples
`define RESET_CARRIER_INC  32'd258

////////////////////////////////////////
// keyboard scan codes, make only
`define BREAK_OFFSET       8'h80
`define SC_1               8'h16
`define SC_2               8'h1E
`define SC_3               8'h26
`define SC_4               8'h25
`define SC_5               8'h2E
`define SC_6               8'h36
`define SC_7               8'h3D
`define SC_8               8'h3E
`define SC_N               8'h31
`define SC_M               8'h3A
`define SC_F1              8'h05
`define SC_F2              8'h06

////////////////////////////////////////
// apb byte offsets
`define REG_CTRL           8'h00
`define REG_CARRIER_INC    8'h04
`define REG_FSK_INC        8'h08
`define REG_ARM_STATUS     8'h0C
`define REG_KEYS           8'h10
`define TRACE0_BASE        8'h40
`define TRACE1_BASE        8'h80

`endif

// ==== verilog/dds_scope_pkg.sv ====
`include "dds_scope_params.svh"

package dds_scope_pkg;

   // tuning word or accumulator phase
   typedef logic [`PHASE_W-1:0] phase_t;

   // unsigned waveform sample
   typedef logic [`SAMPLE_W-1:0] sample_t;

   // bit 0 is key 1 ... bit 7 key 8, then N, M, F1, F2
   typedef logic [`KEY_COUNT-1:0] key_mask_t;

   typedef logic [$clog2(`TRACE_DEPTH)-1:0] trace_idx_t;

   // waveform shape for the carrier
   typedef enum logic [1:0]
   {
      SIG_SAW      = 2'd0,
      SIG_SQUARE   = 2'd1,
      SIG_TRIANGLE = 2'd2,
      SIG_DATA     = 2'd3
   } sig_sel_t;

   // keying applied to the modulated output
   typedef enum logic [1:0]
   {
      MOD_ASK  = 2'd0,
      MOD_BPSK = 2'd1,
      MOD_FSK  = 2'd2,
      MOD_OFF  = 2'd3
   } mod_sel_t;

endpackage

// ==== verilog/key_hold_tracker.sv ====
`timescale 1ns/1ps
`include "dds_scope_params.svh"

module key_hold_tracker
(
   input  logic                     CLK_25MHZ,
   input  logic                     reset_from_key,
   input  logic                     event_valid,
   input  logic [7:0]               event_code,
   output dds_scope_pkg::key_mask_t held_keys
);
   import dds_scope_pkg::*;

   // make codes in bitmap order
   localparam logic [7:0] MAKE_CODE [`KEY_COUNT] = '{
      `SC_1,
      `SC_2,
      `SC_3,
      `SC_4,
      `SC_5,
      `SC_6,
      `SC_7,
      `SC_8,
      `SC_N,
      `SC_M,
      `SC_F1,
      `SC_F2
   };

   key_mask_t held_q;

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         held_q <= '0;
      end
      else if (event_valid)
      begin
         for (int i = 0; i < `KEY_COUNT; i++)
         begin
            if (event_code == MAKE_CODE[i])
            begin
               held_q[i] <= 1'b1;                  // key went down
            end
            else if (event_code == MAKE_CODE[i] + `BREAK_OFFSET)
            begin
               held_q[i] <= 1'b0;                  // key released
            end
         end
      end
   end

   assign held_keys = held_q;   // unknown codes fall through

endmodule

// ==== verilog/lfsr_bit_gen.sv ====
`timescale 1ns/1ps
`include "dds_scope_params.svh"

module lfsr_bit_gen
(
   input  logic CLK_25MHZ,
   input  logic reset_from_key,
   output logic data_bit
);

   localparam int TICK_W = ($clog2(`LFSR_TICK) > 0) ? $clog2(`LFSR_TICK) : 1;

   logic [TICK_W-1:0] tick_cnt;
   logic [4:0]        state;

   // x^5 + x^3 + 1, period 31
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         tick_cnt <= '0;
         state    <= 5'b00001;
      end
      else if (tick_cnt == TICK_W'(`LFSR_TICK - 1))
      begin
         tick_cnt <= '0;
         state    <= {state[3:0], state[4] ^ state[2]};
      end
      else
      begin
         tick_cnt <= tick_cnt + 1'b1;
      end
   end

   assign data_bit = state[0];

   // zero state would lock the generator forever
   a_state_nonzero: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      state != 5'b00000)
      else $error("lfsr state stuck at zero");

endmodule

// ==== verilog/dds_modulator.sv ====
`timescale 1ns/1ps
`include "dds_scope_params.svh"

module dds_modulator
(
   input  logic                    CLK_25MHZ,
   input  logic                    reset_from_key,
   input  logic                    data_bit,
   input  dds_scope_pkg::sig_sel_t sig_sel,
   input  dds_scope_pkg::mod_sel_t mod_sel,
   input  dds_scope_pkg::phase_t   carrier_inc,
   input  dds_scope_pkg::phase_t   fsk_inc,
   output dds_scope_pkg::sample_t  sig_sample,
   output dds_scope_pkg::sample_t  mod_sample
);
   import dds_scope_pkg::*;

   localparam sample_t MIDSCALE = {1'b1, {(`SAMPLE_W-1){1'b0}}};

   phase_t  carrier_phase;
   phase_t  fsk_phase;
   sample_t sig_next;
   sample_t mod_next;

   // phase to sample, top bits drive every shape
   function automatic sample_t shape(input phase_t p, input sig_sel_t sel, input logic bit_in);
      sample_t s;
      case (sel)
         SIG_SAW:
            s = p[`PHASE_W-1 -: `SAMPLE_W];
         SIG_SQUARE:
            s = {`SAMPLE_W{p[`PHASE_W-1]}};
         SIG_TRIANGLE:
            s = p[`PHASE_W-1] ? ~p[`PHASE_W-2 -: `SAMPLE_W] : p[`PHASE_W-2 -: `SAMPLE_W];
         default:
            s = {`SAMPLE_W{bit_in}};               // raw data bit
      endcase
      return s;
   endfunction

   ////////////////////////////////////////
   // phase accumulators
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         carrier_phase <= '0;
         fsk_phase     <= '0;
      end
      else
      begin
         carrier_phase <= carrier_phase + carrier_inc;
         fsk_phase     <= fsk_phase + (data_bit ? fsk_inc : carrier_inc);  // mark vs space
      end
   end

   ////////////////////////////////////////
   // shaping and keying
   always_comb
   begin
      sig_next = shape(carrier_phase, sig_sel, data_bit);
      case (mod_sel)
         MOD_ASK:
            mod_next = data_bit ? sig_next : '0;
         MOD_BPSK:
            mod_next = data_bit ? sig_next : ~sig_next;   // 180 deg flip
         MOD_FSK:
            mod_next = shape(fsk_phase, sig_sel, data_bit);
         default:
            mod_next = MIDSCALE;
      endcase
   end

   // output register, one cycle behind the phase
   always_ff @(posedge CLK_25MHZ)
   begin
      sig_sample <= sig_next;
      mod_sample <= mod_next;
   end

endmodule

// ==== verilog/trace_capture.sv ====
`timescale 1ns/1ps
`include "dds_scope_params.svh"

module trace_capture
#(
   parameter int DEPTH = `TRACE_DEPTH,
   parameter int DECIM = `TRACE_DECIM
)
(
   input  logic                      CLK_25MHZ,
   input  logic                      reset_from_key,
   input  logic                      arm,
   input  dds_scope_pkg::sample_t    sample_in,
   input  dds_scope_pkg::trace_idx_t rd_index,
   output dds_scope_pkg::sample_t    rd_sample,
   output logic                      done
);
   import dds_scope_pkg::*;

   localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int IDX_W  = $clog2(DEPTH + 1);             // must reach DEPTH
   localparam int DEC_W  = (DECIM > 1) ? $clog2(DECIM) : 1;

   sample_t           buffer [DEPTH];
   logic [IDX_W-1:0]  wr_idx;
   logic [DEC_W-1:0]  dec_cnt;
   logic              capturing;
   logic              take;

   assign capturing = (wr_idx < IDX_W'(DEPTH));
   assign take      = capturing && (dec_cnt == DEC_W'(DECIM - 1));

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         wr_idx  <= IDX_W'(DEPTH);                   // idle
         dec_cnt <= '0;
         done    <= 1'b0;
      end
      else if (arm)
      begin
         wr_idx  <= IDX_W'(1);                       // sample 0 taken now
         dec_cnt <= '0;
         done    <= (DEPTH == 1);
      end
      else if (take)
      begin
         wr_idx  <= wr_idx + 1'b1;
         dec_cnt <= '0;
         done    <= (wr_idx == IDX_W'(DEPTH - 1));
      end
      else if (capturing)
      begin
         dec_cnt <= dec_cnt + 1'b1;
      end
   end

   // sample storage
   always_ff @(posedge CLK_25MHZ)
   begin
      if (arm)
         buffer[0] <= sample_in;
      else if (take)
         buffer[ADDR_W'(wr_idx)] <= sample_in;
   end

   assign rd_sample = (rd_index < DEPTH) ? buffer[ADDR_W'(rd_index)] : '0;

   a_idx_range: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      wr_idx <= IDX_W'(DEPTH))
      else $error("trace write index past depth");

endmodule

// ==== verilog/apb_regs.sv ====
`timescale 1ns/1ps
`include "dds_scope_params.svh"

module apb_regs
(
   input  logic                      CLK_25MHZ,
   input  logic                      reset_from_key,
   input  logic                      psel,
   input  logic                      penable,
   input  logic                      pwrite,
   input  logic [7:0]                paddr,
   input  dds_scope_pkg::phase_t     pwdata,
   input  dds_scope_pkg::key_mask_t  held_keys,
   input  dds_scope_pkg::sample_t    trace0_sample,
   input  dds_scope_pkg::sample_t    trace1_sample,
   input  logic                      trace0_done,
   input  logic                      trace1_done,
   output dds_scope_pkg::phase_t     prdata,
   output dds_scope_pkg::sig_sel_t   sig_sel,
   output dds_scope_pkg::mod_sel_t   mod_sel,
   output dds_scope_pkg::phase_t     carrier_inc,
   output dds_scope_pkg::phase_t     fsk_inc,
   output logic                      arm,
   output dds_scope_pkg::trace_idx_t rd_index
);
   import dds_scope_pkg::*;

   localparam logic [7:0] WIN_MASK = 8'hC0;   // 64-byte trace windows

   logic wr_en;

   assign wr_en = psel & penable & pwrite;   // access phase only

   ////////////////////////////////////////
   // control registers
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         sig_sel     <= SIG_SAW;
         mod_sel     <= MOD_ASK;
         carrier_inc <= `RESET_CARRIER_INC;
         fsk_inc     <= '0;
         arm         <= 1'b0;
      end
      else
      begin
         arm <= wr_en && (paddr == `REG_ARM_STATUS);   // single-cycle strobe
         if (wr_en && paddr == `REG_CTRL)
         begin
            sig_sel <= sig_sel_t'(pwdata[1:0]);
            mod_sel <= mod_sel_t'(pwdata[5:4]);
         end
         if (wr_en && paddr == `REG_CARRIER_INC)
            carrier_inc <= pwdata;
         if (wr_en && paddr == `REG_FSK_INC)
            fsk_inc <= pwdata;
      end
   end

   // word offset inside either trace window
   assign rd_index = paddr[5:2];

   ////////////////////////////////////////
   // readback
   always_comb
   begin
      prdata = '0;
      if ((paddr & WIN_MASK) == `TRACE0_BASE)
         prdata = phase_t'(trace0_sample);
      else if ((paddr & WIN_MASK) == `TRACE1_BASE)
         prdata = phase_t'(trace1_sample);
      else
         case (paddr)
            `REG_CTRL:        prdata = phase_t'({mod_sel, 2'b00, sig_sel});
            `REG_CARRIER_INC: prdata = carrier_inc;
            `REG_FSK_INC:     prdata = fsk_inc;
            `REG_ARM_STATUS:  prdata = phase_t'({trace1_done, trace0_done});
            `REG_KEYS:        prdata = phase_t'(held_keys);
            default:          prdata = '0;                  // hole in the map
         endcase
   end

   a_apb_setup: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      $rose(penable) |-> psel)
      else $error("penable raised without psel");

endmodule

// ==== verilog/dds_scope_top.sv ====
`timescale 1ns/1ps
`include "dds_scope_params.svh"

module dds_scope_top
(
   input  logic                  CLK_25MHZ,
   input  logic                  reset_from_key,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [7:0]            paddr,
   input  dds_scope_pkg::phase_t pwdata,
   input  logic                  event_valid,
   input  logic [7:0]            event_code,
   output dds_scope_pkg::phase_t prdata
);
   import dds_scope_pkg::*;

   key_mask_t  held_keys;
   logic       data_bit;
   sig_sel_t   sig_sel;
   mod_sel_t   mod_sel;
   phase_t     carrier_inc;
   phase_t     fsk_inc;
   logic       arm;
   trace_idx_t rd_index;
   sample_t    trace_in     [2];   // 0 carrier, 1 modulated
   sample_t    trace_sample [2];
   logic       trace_done   [2];

   key_hold_tracker i_key_hold_tracker
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .event_valid    (event_valid),
      .event_code     (event_code),
      .held_keys      (held_keys)
   );

   lfsr_bit_gen i_lfsr_bit_gen
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .data_bit       (data_bit)
   );

   dds_modulator i_dds_modulator
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .data_bit       (data_bit),
      .sig_sel        (sig_sel),
      .mod_sel        (mod_sel),
      .carrier_inc    (carrier_inc),
      .fsk_inc        (fsk_inc),
      .sig_sample     (trace_in[0]),
      .mod_sample     (trace_in[1])
   );

   ////////////////////////////////////////
   // scope traces
   for (genvar g = 0; g < 2; g++)
   begin : g_trace
      trace_capture
      #(
         .DEPTH (`TRACE_DEPTH),
         .DECIM (`TRACE_DECIM)
      )
      i_trace_capture
      (
         .CLK_25MHZ      (CLK_25MHZ),
         .reset_from_key (reset_from_key),
         .arm            (arm),
         .sample_in      (trace_in[g]),
         .rd_index       (rd_index),
         .rd_sample      (trace_sample[g]),
         .done           (trace_done[g])
      );
   end

   apb_regs i_apb_regs
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .psel           (psel),
      .penable        (penable),
      .pwrite         (pwrite),
      .paddr          (paddr),
      .pwdata         (pwdata),
      .held_keys      (held_keys),
      .trace0_sample  (trace_sample[0]),
      .trace1_sample  (trace_sample[1]),
      .trace0_done    (trace_done[0]),
      .trace1_done    (trace_done[1]),
      .prdata         (prdata),
      .sig_sel        (sig_sel),
      .mod_sel        (mod_sel),
      .carrier_inc    (carrier_inc),
      .fsk_inc        (fsk_inc),
      .arm            (arm),
      .rd_index       (rd_index)
   );

endmodule

// ==== tb/tb_dds_scope.sv ====
`timescale 1ns/1ps
`include "dds_scope_params.svh"

module tb_dds_scope;
   import dds_scope_pkg::*;

   localparam int ARM_TO_DONE = 1 + (`TRACE_DEPTH - 1) * `TRACE_DECIM;
   localparam int ROUNDS = 12;                  // ten captures, registers, keys
   localparam longint TIMEOUT_NS = longint'(ROUNDS) * (ARM_TO_DONE + 200) * 40;
   localparam int POLL_LIMIT = 2 * ARM_TO_DONE;

   // make codes in bitmap order
   localparam logic [7:0] KEY_MAKE [`KEY_COUNT] = '{
      `SC_1, `SC_2, `SC_3, `SC_4, `SC_5, `SC_6,
      `SC_7, `SC_8, `SC_N, `SC_M, `SC_F1, `SC_F2
   };

   logic        CLK_25MHZ = 1'b0;
   logic        reset_from_key;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [7:0]  paddr;
   phase_t      pwdata;
   logic        event_valid;
   logic [7:0]  event_code;
   phase_t      prdata;

   logic [15:0] rng_state = 16'd56;

   // model state
   phase_t      m_carrier;
   phase_t      m_fsk;
   phase_t      m_carrier_inc;
   phase_t      m_fsk_inc;
   sig_sel_t    m_sig_sel;
   mod_sel_t    m_mod_sel;
   logic [4:0]  m_lfsr;
   int          m_tick;
   sample_t     m_sig;
   sample_t     m_mod;
   logic        m_arm;
   sample_t     m_buf [2][`TRACE_DEPTH];
   int          m_count [2];                   // samples stored so far
   int          m_wait [2];
   logic [1:0]  m_done;
   key_mask_t   m_keys;

   dds_scope_top i_dds_scope_top
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .psel           (psel),
      .penable        (penable),
      .pwrite         (pwrite),
      .paddr          (paddr),
      .pwdata         (pwdata),
      .event_valid    (event_valid),
      .event_code     (event_code),
      .prdata         (prdata)
   );

   always #20 CLK_25MHZ = ~CLK_25MHZ;   // 25 MHz

   ////////////////////////////////////////
   // random source is a 16-bit galois lfsr
   function automatic logic [15:0] galois_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         r = {r[30:0], rng_state[0]};
         rng_state = galois_step(rng_state);
      end
      return r;
   endfunction

   // waveform shapes from the phase
   function automatic sample_t shape_sample(input phase_t p, input sig_sel_t sel, input logic b);
      case (sel)
         SIG_SAW:      return p[31:20];
         SIG_SQUARE:   return p[31] ? 12'hFFF : 12'h000;
         SIG_TRIANGLE: return p[31] ? ~p[30:19] : p[30:19];
         default:      return b ? 12'hFFF : 12'h000;
      endcase
   endfunction

   function automatic sample_t keyed_sample(input mod_sel_t ms, input sample_t cs,
                                            input phase_t fp, input sig_sel_t ss, input logic b);
      case (ms)
         MOD_ASK:  return b ? cs : 12'h000;
         MOD_BPSK: return b ? cs : ~cs;
         MOD_FSK:  return shape_sample(fp, ss, b);
         default:  return 12'h800;           // midscale
      endcase
   endfunction

   ////////////////////////////////////////
   // cycle model fed from pre-edge values
   always @(posedge CLK_25MHZ)
   begin
      logic    bit_now;
      logic    wr;
      sample_t carrier_shape;
      sample_t src [2];
      bit_now       = m_lfsr[0];
      wr            = psel && penable && pwrite;
      carrier_shape = shape_sample(m_carrier, m_sig_sel, bit_now);
      src[0]        = m_sig;
      src[1]        = m_mod;
      m_sig <= carrier_shape;              // one cycle behind the phase
      m_mod <= keyed_sample(m_mod_sel, carrier_shape, m_fsk, m_sig_sel, bit_now);
      if (reset_from_key)
      begin
         m_sig_sel     <= SIG_SAW;
         m_mod_sel     <= MOD_ASK;
         m_carrier_inc <= `RESET_CARRIER_INC;
         m_fsk_inc     <= '0;
         m_arm         <= 1'b0;
         m_lfsr        <= 5'b00001;
         m_tick        <= 0;
         m_carrier     <= '0;
         m_fsk         <= '0;
         m_keys        <= '0;
         m_done        <= '0;
         m_count[0]    <= `TRACE_DEPTH;    // idle
         m_count[1]    <= `TRACE_DEPTH;
      end
      else
      begin
         m_arm <= wr && (paddr == `REG_ARM_STATUS);
         if (wr && paddr == `REG_CTRL)
         begin
            m_sig_sel <= sig_sel_t'(pwdata[1:0]);
            m_mod_sel <= mod_sel_t'(pwdata[5:4]);
         end
         if (wr && paddr == `REG_CARRIER_INC)
            m_carrier_inc <= pwdata;
         if (wr && paddr == `REG_FSK_INC)
            m_fsk_inc <= pwdata;
         if (m_tick == `LFSR_TICK - 1)
         begin
            m_tick <= 0;
            m_lfsr <= {m_lfsr[3:0], m_lfsr[4] ^ m_lfsr[2]};
         end
         else
            m_tick <= m_tick + 1;
         m_carrier <= m_carrier + m_carrier_inc;
         m_fsk     <= m_fsk + (bit_now ? m_fsk_inc : m_carrier_inc);
         if (event_valid)
            for (int k = 0; k < `KEY_COUNT; k++)
            begin
               if (event_code == KEY_MAKE[k])
                  m_keys[k] <= 1'b1;
               else if (event_code == 8'(KEY_MAKE[k] + `BREAK_OFFSET))
                  m_keys[k] <= 1'b0;
            end
         for (int t = 0; t < 2; t++)
         begin
            if (m_arm)
            begin
               m_buf[t][0] <= src[t];
               m_count[t]  <= 1;
               m_wait[t]   <= 0;
               m_done[t]   <= 1'b0;
            end
            else if (m_count[t] < `TRACE_DEPTH)
            begin
               if (m_wait[t] == `TRACE_DECIM - 1)
               begin
                  m_buf[t][m_count[t]] <= src[t];
                  m_count[t] <= m_count[t] + 1;
                  m_wait[t]  <= 0;
                  if (m_count[t] == `TRACE_DEPTH - 1)
                     m_done[t] <= 1'b1;    // last sample lands
               end
               else
                  m_wait[t] <= m_wait[t] + 1;
            end
         end
      end
   end

   ////////////////////////////////////////
   // failure reporting and compares
   task automatic stop_on_error();
      $display("TEST RESULT: FAIL");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic report_problem(input string msg);
      $display("%s at %0t ns", msg, $time);
      stop_on_error();
   endtask

   task automatic check_sample(input string name, input sample_t exp, input sample_t act);
      if (act !== exp)
      begin
         $display("FAILED at %0t ns: %s expected %h actual %h", $time, name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_keys(input string name, input key_mask_t exp, input key_mask_t act);
      if (act !== exp)
      begin
         $display("FAILED at %0t ns: %s expected %b actual %b", $time, name, exp, act);
         stop_on_error();
      end
   endtask

   task automatic check_word(input string name, input phase_t exp, input phase_t act);
      if (act !== exp)
      begin
         $display("FAILED at %0t ns: %s expected %h actual %h", $time, name, exp, act);
         stop_on_error();
      end
   endtask

   ////////////////////////////////////////
   // bus and event drivers
   task automatic write_reg(input logic [7:0] addr, input phase_t data);
      @(posedge CLK_25MHZ);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge CLK_25MHZ);
      penable <= 1'b1;
      @(posedge CLK_25MHZ);                // write lands here
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] addr, output phase_t data);
      @(posedge CLK_25MHZ);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge CLK_25MHZ);
      penable <= 1'b1;
      @(negedge CLK_25MHZ);
      data = prdata;                       // mid access cycle
      @(posedge CLK_25MHZ);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic write_read_back(input logic [7:0] addr, input string name, input phase_t mask);
      phase_t wval;
      phase_t data;
      wval = random_bits(32);
      write_reg(addr, wval);
      read_reg(addr, data);
      check_word(name, wval & mask, data);
   endtask

   task automatic send_key_event(input logic [7:0] code);
      @(posedge CLK_25MHZ);
      event_valid <= 1'b1;
      event_code  <= code;
      @(posedge CLK_25MHZ);
      event_valid <= 1'b0;
   endtask

   task automatic wait_for_done();
      phase_t status;
      int     polls;
      status = '0;
      polls  = 0;
      while (status[0] !== 1'b1)
      begin
         if (polls == POLL_LIMIT)
            report_problem("trace 0 never reported done");
         read_reg(`REG_ARM_STATUS, status);
         check_word("arm_status", phase_t'(m_done), status);
         polls++;
      end
   endtask

   task automatic compare_traces();
      phase_t data;
      for (int i = 0; i < `TRACE_DEPTH; i++)
      begin
         read_reg(8'(`TRACE0_BASE + 4 * i), data);
         check_sample($sformatf("trace0[%0d]", i), m_buf[0][i], data[`SAMPLE_W-1:0]);
         check_word($sformatf("trace0[%0d] upper bits", i), '0, data >> `SAMPLE_W);
         read_reg(8'(`TRACE1_BASE + 4 * i), data);
         check_sample($sformatf("trace1[%0d]", i), m_buf[1][i], data[`SAMPLE_W-1:0]);
         check_word($sformatf("trace1[%0d] upper bits", i), '0, data >> `SAMPLE_W);
      end
   endtask

   // gap above zero re-arms partway through the capture
   task automatic capture_round(input logic [1:0] ss, input logic [1:0] ms, input int gap);
      phase_t car;
      phase_t fsk;
      car = random_bits(30);
      fsk = random_bits(30);
      write_reg(`REG_CTRL, {26'b0, ms, 2'b00, ss});
      write_reg(`REG_CARRIER_INC, car);
      write_reg(`REG_FSK_INC, fsk);
      write_reg(`REG_ARM_STATUS, '0);
      if (gap > 0)
      begin
         repeat (gap) @(posedge CLK_25MHZ);
         write_reg(`REG_ARM_STATUS, '0);
      end
      wait_for_done();
      compare_traces();
   endtask

   ////////////////////////////////////////
   // watchdog
   initial
   begin
      #(TIMEOUT_NS);
      $display("simulation timed out after %0d ns", TIMEOUT_NS);
      $display("TEST RESULT: FAIL");
      $fatal(1, "watchdog expired");
   end

   initial
   begin
      phase_t      data;
      int          kind;
      int          key;
      logic [7:0]  code;
      psel           = 1'b0;
      penable        = 1'b0;
      pwrite         = 1'b0;
      paddr          = '0;
      pwdata         = '0;
      event_valid    = 1'b0;
      event_code     = '0;
      reset_from_key = 1'b1;
      repeat (5) @(posedge CLK_25MHZ);
      reset_from_key <= 1'b0;

      // reset values
      read_reg(`REG_CTRL, data);
      check_word("ctrl", '0, data);
      read_reg(`REG_CARRIER_INC, data);
      check_word("carrier_inc", `RESET_CARRIER_INC, data);
      read_reg(`REG_FSK_INC, data);
      check_word("fsk_inc", '0, data);
      read_reg(`REG_ARM_STATUS, data);
      check_word("arm_status", '0, data);
      read_reg(`REG_KEYS, data);
      check_word("keys", '0, data);

      for (int n = 0; n < 4; n++)
      begin
         write_read_back(`REG_CTRL, "ctrl", 32'h0000_0033);
         write_read_back(`REG_CARRIER_INC, "carrier_inc", '1);
         write_read_back(`REG_FSK_INC, "fsk_inc", '1);
      end
      write_read_back(8'h14, "unmapped", '0);

      // make, break and stray codes
      for (int n = 0; n < 32; n++)
      begin
         kind = random_bits(2);
         key  = random_bits(4) % `KEY_COUNT;
         case (kind)
            1:       code = 8'(KEY_MAKE[key] + `BREAK_OFFSET);
            2:       code = 8'(random_bits(8));
            default: code = KEY_MAKE[key];
         endcase
         send_key_event(code);
         read_reg(`REG_KEYS, data);
         check_keys("held_keys", m_keys, key_mask_t'(data));
         check_word("keys upper bits", '0, data >> `KEY_COUNT);
      end

      for (int s = 0; s < 4; s++)
         capture_round(2'(s), 2'(random_bits(2)), 0);
      capture_round(2'(random_bits(2)), MOD_ASK, 0);
      capture_round(2'(random_bits(2)), MOD_BPSK, 0);
      capture_round(2'(random_bits(2)), MOD_OFF, 0);
      capture_round(SIG_SAW, MOD_FSK, 0);        // shapes that show the fsk phase
      capture_round(SIG_TRIANGLE, MOD_FSK, 0);
      capture_round(2'(random_bits(2)), MOD_BPSK, 10 + int'(random_bits(5)));

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

// ==== tb.f ====
+incdir+verilog
verilog/dds_scope_pkg.sv
verilog/key_hold_tracker.sv
verilog/lfsr_bit_gen.sv
verilog/dds_modulator.sv
verilog/trace_capture.sv
verilog/apb_regs.sv
verilog/dds_scope_top.sv
tb/tb_dds_scope.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_dds_scope -o sim_tb

out=$(./obj_dir/sim_tb 2>&1 || true)
echo "$out"

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
   exit 0
fi
exit 1
